/* mult_apb.f */
logic/mult_pkg.sv
logic/apb_mult_regs.sv
logic/operand_conditioner.sv
logic/shift_add_core.sv
logic/sign_restore.sv
logic/mult_apb_top.sv
dv/tb_clock_gen.sv
dv/mult_apb_tb.sv

/* Makefile */
# Verilator build and run for the APB signed multiplier
# Any variable can be overridden on the command line, e.g. make run TOP=mult_apb_tb

VERILATOR ?= verilator
TOP       ?= mult_apb_tb
FILELIST  ?= mult_apb.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The simulation output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

/* dv/mult_apb_tb.sv */
`timescale 1ns/100ps
// Self-checking testbench for DW of 16 that drives APB on falling edges and stops at the first error
module mult_apb_tb
	import mult_pkg::*;
();

	// ===================================================================
	// Run sizing
	// ===================================================================
	localparam int DW             = MULT_DW_DEFAULT;
	localparam int RESET_CYCLES   = 10;
	localparam int N_RANDOM       = 200;
	localparam int N_CORNER       = 7;
	// Reset and readback, busy rejection and error recovery count as one job each
	localparam int N_JOBS         = N_RANDOM + N_CORNER + 3;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_JOBS * (DW + 40);
	localparam int POLL_LIMIT     = DW + 10;
	// Outputs are read in the low phase of the access cycle, where they are settled
	localparam int SAMPLE_DELAY   = 10;

	localparam logic [DW-1:0] MIN_VAL = {1'b1, {(DW-1){1'b0}}};
	localparam logic [DW-1:0] MAX_VAL = ~MIN_VAL;
	localparam logic [DW-1:0] ONE     = DW'(1);
	localparam logic [DW-1:0] NEG_ONE = '1;
	localparam logic [DW-1:0] ZERO    = '0;

	logic        clk;
	logic        rst;
	apb_req_t    apb;
	apb_rsp_t    apb_rsp;
	logic        done;
	logic [31:0] lfsr_state = 32'hed06_2427;
	int          cycle_count = 0;

	tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
		.clk(clk), .rst(rst)
	);

	mult_apb_top #(.DW(DW)) mult_apb_top_i (
		.clk(clk), .rst(rst), .apb(apb), .apb_rsp(apb_rsp), .done(done)
	);

	// ===================================================================
	// Failure reporting and random numbers
	// ===================================================================
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	// Taps 32, 22, 2 and 1 give a maximal-length sequence
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Operand as software sees it on the 32-bit bus
	// Every bit above the operand repeats its sign bit
	function automatic logic [31:0] sext(input logic [DW-1:0] v);
		logic [31:0] w;
		w         = {32{v[DW-1]}};
		w[DW-1:0] = v;
		return w;
	endfunction

	// Signed product from integer arithmetic, truncated to 2*DW bits and widened again
	function automatic logic [31:0] model_product(input logic [DW-1:0] a, input logic [DW-1:0] b);
		longint          x;
		longint          y;
		longint          p;
		logic [2*DW-1:0] low;
		logic [31:0]     w;
		x   = longint'($signed(a));
		y   = longint'($signed(b));
		p   = x * y;
		low = p[2*DW-1:0];
		w   = {32{low[2*DW-1]}};
		w[2*DW-1:0] = low;
		return w;
	endfunction

	// ===================================================================
	// APB transfers
	// ===================================================================

	// Setup, access and back to idle, one falling edge each
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic err;
		@(negedge clk);
		apb.paddr   = addr;
		apb.pwdata  = data;
		apb.pwrite  = 1'b1;
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		@(negedge clk);
		apb.penable = 1'b1;
		#SAMPLE_DELAY;
		err = apb_rsp.pslverr;
		assert (apb_rsp.pready === 1'b1)
		else
			stop_on_error($sformatf("Mismatch at %0t: pready low on write to 0x%02h",
				$time, addr));
		@(negedge clk);
		apb.psel    = 1'b0;
		apb.penable = 1'b0;
		apb.pwrite  = 1'b0;
		assert (err === exp_err)
		else
			stop_on_error($sformatf("Mismatch at %0t: pslverr %0b on write to 0x%02h, expected %0b",
				$time, err, addr, exp_err));
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk);
		apb.paddr   = addr;
		apb.pwrite  = 1'b0;
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		@(negedge clk);
		apb.penable = 1'b1;
		#SAMPLE_DELAY;
		data = apb_rsp.prdata;
		err  = apb_rsp.pslverr;
		assert (apb_rsp.pready === 1'b1)
		else
			stop_on_error($sformatf("Mismatch at %0t: pready low on read of 0x%02h",
				$time, addr));
		@(negedge clk);
		apb.psel    = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
		input logic exp_err, input string what);
		logic [31:0] data;
		logic        err;
		read_reg(addr, data, err);
		assert (err === exp_err)
		else
			stop_on_error($sformatf("Mismatch at %0t: pslverr %0b on %s, expected %0b",
				$time, err, what, exp_err));
		assert (data === exp_data)
		else
			stop_on_error($sformatf("Mismatch at %0t: %s read 0x%08h, expected 0x%08h",
				$time, what, data, exp_data));
	endtask

	// ===================================================================
	// Job flow
	// ===================================================================

	// Until done shows, STATUS must report busy; once it does, the done port agrees
	task automatic wait_done();
		logic [31:0] status;
		logic        err;
		logic        seen;
		int          polls;
		seen  = 1'b0;
		polls = 0;
		while (!seen && polls < POLL_LIMIT)
		begin
			read_reg(ADDR_STATUS, status, err);
			polls++;
			assert (err === 1'b0)
			else
				stop_on_error($sformatf("Mismatch at %0t: pslverr on STATUS read", $time));
			if (status[STATUS_DONE_BIT])
			begin
				seen = 1'b1;
				assert (done === 1'b1)
				else
					stop_on_error($sformatf("Mismatch at %0t: done port low while STATUS shows done",
						$time));
			end
			else
			begin
				assert (status[STATUS_BUSY_BIT] === 1'b1)
				else
					stop_on_error($sformatf("Mismatch at %0t: STATUS 0x%08h shows neither busy nor done",
						$time, status));
			end
		end
		assert (seen)
		else
			stop_on_error($sformatf("STATUS did not show done within %0d reads", POLL_LIMIT));
	endtask

	task automatic run_job(input logic [DW-1:0] a, input logic [DW-1:0] b, input int gap,
		input logic readback);
		write_reg(ADDR_OP_A, sext(a), 1'b0);
		write_reg(ADDR_OP_B, sext(b), 1'b0);
		if (readback)
		begin
			read_expect(ADDR_OP_A, sext(a), 1'b0, "OP_A");
			read_expect(ADDR_OP_B, sext(b), 1'b0, "OP_B");
		end
		repeat (gap) @(negedge clk);
		write_reg(ADDR_CTRL, 32'(1) << CTRL_START_BIT, 1'b0);
		wait_done();
		read_expect(ADDR_RESULT, model_product(a, b), 1'b0,
			$sformatf("RESULT of %0d * %0d", $signed(a), $signed(b)));
	endtask

	// ===================================================================
	// Global timeout
	// ===================================================================
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		assert (cycle_count < TIMEOUT_CYCLES)
		else
			stop_on_error($sformatf("Timeout: run went past %0d clock cycles", TIMEOUT_CYCLES));
	end

	// ===================================================================
	// Test sequence
	// ===================================================================
	initial
	begin
		logic [DW-1:0] a;
		logic [DW-1:0] b;
		logic [31:0]   r;
		apb = '0;
		wait (rst === 1'b1);

		// Idle state straight out of reset
		read_expect(ADDR_STATUS, 32'h0, 1'b0, "STATUS after reset");
		assert (done === 1'b0)
		else
			stop_on_error($sformatf("Mismatch at %0t: done port high after reset", $time));
		read_expect(ADDR_RESULT, 32'h0, 1'b0, "RESULT after reset");

		// Operand registers read back sign-extended
		write_reg(ADDR_OP_A, sext(MIN_VAL), 1'b0);
		write_reg(ADDR_OP_B, sext(MAX_VAL), 1'b0);
		read_expect(ADDR_OP_A, sext(MIN_VAL), 1'b0, "OP_A readback");
		read_expect(ADDR_OP_B, sext(MAX_VAL), 1'b0, "OP_B readback");

		// Corners around zero, one, minus one and the extremes of the range
		run_job(ZERO, MAX_VAL, 0, 1'b0);
		run_job(ONE, MIN_VAL, 0, 1'b0);
		run_job(NEG_ONE, MAX_VAL, 0, 1'b0);
		run_job(NEG_ONE, NEG_ONE, 0, 1'b0);
		run_job(MIN_VAL, MIN_VAL, 0, 1'b0);
		run_job(MIN_VAL, MAX_VAL, 0, 1'b0);
		run_job(MAX_VAL, MIN_VAL, 0, 1'b0);

		// Random operands with a random idle gap and an occasional readback
		for (int i = 0; i < N_RANDOM; i++)
		begin
			r = rand_bits(DW);
			a = r[DW-1:0];
			r = rand_bits(DW);
			b = r[DW-1:0];
			run_job(a, b, int'(rand_bits(2)), rand_bits(1) == 32'h1);
		end

		// An operand write in the middle of a job is refused and leaves the job intact
		r = rand_bits(DW);
		a = r[DW-1:0];
		r = rand_bits(DW);
		b = r[DW-1:0];
		write_reg(ADDR_OP_A, sext(a), 1'b0);
		write_reg(ADDR_OP_B, sext(b), 1'b0);
		write_reg(ADDR_CTRL, 32'(1) << CTRL_START_BIT, 1'b0);
		read_expect(ADDR_STATUS, 32'(1) << STATUS_BUSY_BIT, 1'b0, "STATUS while busy");
		write_reg(ADDR_OP_A, ~sext(a), 1'b1);
		wait_done();
		read_expect(ADDR_RESULT, model_product(a, b), 1'b0, "RESULT after busy write");
		read_expect(ADDR_OP_A, sext(a), 1'b0, "OP_A after busy write");

		// Illegal accesses change nothing and the next job still works
		read_expect(8'h14, 32'h0, 1'b1, "unmapped read");
		write_reg(8'h20, 32'hdead_beef, 1'b1);
		write_reg(ADDR_RESULT, 32'hdead_beef, 1'b1);
		read_expect(ADDR_RESULT, model_product(a, b), 1'b0, "RESULT after illegal write");
		r = rand_bits(DW);
		a = r[DW-1:0];
		r = rand_bits(DW);
		b = r[DW-1:0];
		run_job(a, b, 0, 1'b1);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps
// Free-running testbench clock with active-low reset released on a falling edge after RESET_CYCLES
module tb_clock_gen
#(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 10
)
(
	output logic clk,
	output logic rst
);

	// Clock starts low so the first edge seen by the DUT is a rising one
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS/2) clk = ~clk;
	end

	// Reset is released away from the rising edge to keep the release race free
	initial
	begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end

endmodule

/* logic/mult_apb_top.sv */
`timescale 1ns/100ps
// Signed APB multiplier with one job at a time and DW held between 2 and 16 by the 32-bit bus
module mult_apb_top
	import mult_pkg::*;
#(
	parameter int DW = MULT_DW_DEFAULT
)
(
	input  logic     clk,
	input  logic     rst,
	input  apb_req_t apb,
	output apb_rsp_t apb_rsp,
	output logic     done
);

	logic [DW-1:0]   op_a;
	logic [DW-1:0]   op_b;
	logic            start;
	logic [DW-1:0]   mag_a;
	logic [DW-1:0]   mag_b;
	logic            neg;
	logic            load;
	logic [2*DW-1:0] product_mag;
	logic            core_done;
	logic [2*DW-1:0] result;
	logic            result_done;

	// The full product has to fit the read data bus
	if (DW < 2 || 2*DW > APB_DW)
	begin : g_dw_check
		$error("DW must lie between 2 and APB_DW/2");
	end

	// ===================================================================
	// Register block, then the datapath in job order
	// ===================================================================
	apb_mult_regs #(.DW(DW)) apb_mult_regs_i (
		.clk(clk), .rst(rst), .apb(apb), .apb_rsp(apb_rsp),
		.op_a(op_a), .op_b(op_b), .start(start),
		.result(result), .result_done(result_done), .done(done)
	);

	operand_conditioner #(.DW(DW)) operand_conditioner_i (
		.clk(clk), .rst(rst), .start(start), .op_a(op_a), .op_b(op_b),
		.mag_a(mag_a), .mag_b(mag_b), .neg(neg), .load(load)
	);

	shift_add_core #(.DW(DW)) shift_add_core_i (
		.clk(clk), .rst(rst), .load(load), .mag_a(mag_a), .mag_b(mag_b),
		.product_mag(product_mag), .core_done(core_done)
	);

	sign_restore #(.DW(DW)) sign_restore_i (
		.clk(clk), .rst(rst), .core_done(core_done), .product_mag(product_mag),
		.neg(neg), .start(start), .result(result), .result_done(result_done)
	);

endmodule

/* logic/sign_restore.sv */
`timescale 1ns/100ps
// Result register that expects neg to stay stable from load until core_done
module sign_restore
	import mult_pkg::*;
#(
	parameter int DW = MULT_DW_DEFAULT
)
(
	input  logic            clk,
	input  logic            rst,
	input  logic            core_done,
	input  logic [2*DW-1:0] product_mag,
	input  logic            neg,
	input  logic            start,
	output logic [2*DW-1:0] result,
	output logic            result_done
);

	logic [2*DW-1:0] product_neg;

	// ===================================================================
	// Two's complement of the magnitude
	// ===================================================================

	// A magnitude of zero stays zero after negation
	assign product_neg = ~product_mag + (2*DW)'(1);

	// ===================================================================
	// Result and done flag
	// ===================================================================
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			result      <= '0;
			result_done <= 1'b0;
		end
		else
		begin
			if (core_done)
			begin
				result      <= neg ? product_neg : product_mag;
				result_done <= 1'b1;
			end
			// The old result stays readable and only its done flag is dropped
			else if (start)
			begin
				result_done <= 1'b0;
			end
		end
	end

	// Done only follows a finished sweep of the core
	assert property (@(posedge clk) disable iff (!rst)
		$rose(result_done) |-> $past(core_done));

endmodule

/* logic/shift_add_core.sv */
`timescale 1ns/100ps
// Unsigned shift-and-add multiplier taking DW cycles after load and accepting no new load mid-run
module shift_add_core
	import mult_pkg::*;
#(
	parameter int DW = MULT_DW_DEFAULT
)
(
	input  logic            clk,
	input  logic            rst,
	input  logic            load,
	input  logic [DW-1:0]   mag_a,
	input  logic [DW-1:0]   mag_b,
	output logic [2*DW-1:0] product_mag,
	output logic            core_done
);

	// Counter just wide enough to index every multiplier bit
	localparam int CW = $clog2(DW);

	logic [DW-1:0]   mplier;
	logic [2*DW-1:0] mcand;
	logic [2*DW-1:0] acc;
	logic [2*DW-1:0] addend;
	logic [CW-1:0]   count;
	logic            running;
	logic            last;

	// ===================================================================
	// Partial product
	// ===================================================================

	// Multiplicand shifted up to the weight of the bit under test
	// Nothing is added when that multiplier bit is zero
	assign addend = mplier[count] ? (mcand << count) : '0;

	// Highest multiplier bit ends the sweep
	assign last = (count == CW'(DW-1));

	// ===================================================================
	// Sweep over the multiplier
	// ===================================================================
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			mplier    <= '0;
			mcand     <= '0;
			acc       <= '0;
			count     <= '0;
			running   <= 1'b0;
			core_done <= 1'b0;
		end
		else
		begin
			core_done <= 1'b0;
			if (load)
			begin
				// Fresh job with operands held locally for the whole sweep
				mplier  <= mag_a;
				mcand   <= {{DW{1'b0}}, mag_b};
				acc     <= '0;
				count   <= '0;
				running <= 1'b1;
			end
			else if (running)
			begin
				acc <= acc + addend;
				if (last)
				begin
					// Accumulator holds the final sum in the same cycle as done
					running   <= 1'b0;
					core_done <= 1'b1;
					count     <= '0;
				end
				else
				begin
					count <= count + CW'(1);
				end
			end
		end
	end

	assign product_mag = acc;

	// Bit index never leaves the multiplier when DW is not a power of two
	assert property (@(posedge clk) disable iff (!rst) int'(count) < DW);

	// Sign restore samples done as a single pulse
	assert property (@(posedge clk) disable iff (!rst) core_done |=> !core_done);

endmodule

/* logic/operand_conditioner.sv */
`timescale 1ns/100ps
// Sign and magnitude split where the most negative operand maps to the unsigned value 2**(DW-1)
module operand_conditioner
	import mult_pkg::*;
#(
	parameter int DW = MULT_DW_DEFAULT
)
(
	input  logic          clk,
	input  logic          rst,
	input  logic          start,
	input  logic [DW-1:0] op_a,
	input  logic [DW-1:0] op_b,
	output logic [DW-1:0] mag_a,
	output logic [DW-1:0] mag_b,
	output logic          neg,
	output logic          load
);

	logic          sign_a;
	logic          sign_b;
	logic [DW-1:0] abs_a;
	logic [DW-1:0] abs_b;

	// ===================================================================
	// Magnitude of each operand
	// ===================================================================

	// The top bit carries the sign in two's complement
	assign sign_a = op_a[DW-1];
	assign sign_b = op_b[DW-1];

	// Negation wraps the most negative value onto itself
	// Read as unsigned it is still the right magnitude
	assign abs_a = sign_a ? (~op_a + DW'(1)) : op_a;
	assign abs_b = sign_b ? (~op_b + DW'(1)) : op_b;

	// ===================================================================
	// Capture on start
	// ===================================================================
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			mag_a <= '0;
			mag_b <= '0;
			neg   <= 1'b0;
			load  <= 1'b0;
		end
		else
		begin
			// Load follows start by one cycle, together with the new magnitudes
			load <= start;
			if (start)
			begin
				mag_a <= abs_a;
				mag_b <= abs_b;
				// Product is negative only when exactly one operand is
				neg   <= sign_a ^ sign_b;
			end
		end
	end

endmodule

/* logic/apb_mult_regs.sv */
`timescale 1ns/100ps
// APB slave with no wait states that rejects operand and control writes while a job is running
module apb_mult_regs
	import mult_pkg::*;
#(
	parameter int DW = MULT_DW_DEFAULT
)
(
	input  logic            clk,
	input  logic            rst,
	input  apb_req_t        apb,
	output apb_rsp_t        apb_rsp,
	output logic [DW-1:0]   op_a,
	output logic [DW-1:0]   op_b,
	output logic            start,
	input  logic [2*DW-1:0] result,
	input  logic            result_done,
	output logic            done
);

	logic              access;
	logic              wr_acc;
	logic              rd_acc;
	logic              addr_rw;
	logic              addr_ro;
	logic              wr_err;
	logic              wr_ok;
	logic              busy;
	logic [APB_DW-1:0] rd_data;

	// ===================================================================
	// Access decode
	// ===================================================================

	// Only the access cycle of a transfer does anything
	assign access = apb.psel & apb.penable;
	assign wr_acc = access & apb.pwrite;
	assign rd_acc = access & ~apb.pwrite;

	// Writable registers and registers that can only be read
	assign addr_rw = (apb.paddr == ADDR_OP_A) || (apb.paddr == ADDR_OP_B) ||
		(apb.paddr == ADDR_CTRL);
	assign addr_ro = (apb.paddr == ADDR_STATUS) || (apb.paddr == ADDR_RESULT);

	// A write fails on a read-only or unmapped address, and on any address while busy
	assign wr_err = wr_acc & (~addr_rw | busy);
	assign wr_ok  = wr_acc & ~wr_err;

	// ===================================================================
	// Operand and control registers
	// ===================================================================
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			op_a  <= '0;
			op_b  <= '0;
			start <= 1'b0;
			busy  <= 1'b0;
		end
		else
		begin
			// Start is a single-cycle pulse in the cycle after the CTRL write
			start <= wr_ok && (apb.paddr == ADDR_CTRL) && apb.pwdata[CTRL_START_BIT];
			if (wr_ok && (apb.paddr == ADDR_OP_A))
				op_a <= apb.pwdata[DW-1:0];
			if (wr_ok && (apb.paddr == ADDR_OP_B))
				op_b <= apb.pwdata[DW-1:0];
			// The same edge that sets busy also clears the old result_done downstream
			if (start)
				busy <= 1'b1;
			else if (result_done)
				busy <= 1'b0;
		end
	end

	// ===================================================================
	// Read data and response
	// ===================================================================
	always_comb
	begin
		rd_data = '0;
		case (apb.paddr)
			ADDR_OP_A:   rd_data = APB_DW'($signed(op_a));
			ADDR_OP_B:   rd_data = APB_DW'($signed(op_b));
			ADDR_STATUS:
			begin
				rd_data[STATUS_BUSY_BIT] = busy;
				rd_data[STATUS_DONE_BIT] = result_done;
			end
			ADDR_RESULT: rd_data = APB_DW'($signed(result));
			// CTRL reads back as zero like any unmapped offset
			default:     rd_data = '0;
		endcase
	end

	always_comb
	begin
		apb_rsp.prdata  = rd_acc ? rd_data : '0;
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = wr_err | (rd_acc & ~(addr_rw | addr_ro));
	end

	assign done = result_done;

	// Penable is only legal inside a selected transfer
	assert property (@(posedge clk) disable iff (!rst) apb.penable |-> apb.psel);

	// A new job never starts on top of one still in the datapath
	assert property (@(posedge clk) disable iff (!rst) start |-> !busy);

endmodule

/* logic/mult_pkg.sv */
// Shared APB types and register map whose 32-bit data bus limits the operand width to 16 bits
package mult_pkg;

	// ===================================================================
	// Bus and operand widths
	// ===================================================================

	// Byte address space of the slave and width of the data bus
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// Operand width used unless the top level is given another one
	localparam int MULT_DW_DEFAULT = 16;

	// ===================================================================
	// APB channel
	// ===================================================================

	// Request from the bridge
	typedef struct packed {
		logic [APB_AW-1:0] paddr;
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	// Response back to the bridge
	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// ===================================================================
	// Register map
	// ===================================================================
	localparam logic [APB_AW-1:0] ADDR_OP_A   = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_OP_B   = 8'h04;
	localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h08;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h0C;
	localparam logic [APB_AW-1:0] ADDR_RESULT = 8'h10;

	// Field positions inside CTRL and STATUS
	localparam int CTRL_START_BIT  = 0;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

endpackage
